/* slam_rsa.f */
+incdir+.
slam_pkg.sv
slam_stage_ctrl.sv
slam_plb_access.sv
slam_nl_capture.sv
slam_rsa_top.sv
tb_slam_checker.sv
tb_slam_rsa.sv

/* run.sh */
#!/bin/bash
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f slam_rsa.f --top-module tb_slam_rsa -o tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Regression failed" sim.log; then
  exit 1
fi
if ! grep -q "Regression passed" sim.log; then
  echo "no result found in sim.log"
  exit 1
fi
exit 0

/* tb_slam_rsa.sv */
`include "slam_macros.svh"

module tb_slam_rsa
  import slam_pkg::*;
;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_STAGES   = 60;
  localparam int WAIT_LIMIT = 200;

  logic      clk;
  logic      sys_rst;
  stage_e    i_stage_val;
  lm_idx_t   i_l_k;
  rsa_data_t i_rk;
  rsa_data_t i_phi;
  logic      o_stage_rdy;
  logic      o_plb_en;
  logic      o_plb_we;
  plb_addr_t o_plb_addr;
  rsa_data_t o_plb_din;
  rsa_data_t i_plb_dout = '0;
  logic      o_init_predict;
  logic      o_init_newlm;
  logic      o_init_update;
  rsa_data_t o_xk, o_yk, o_xita, o_lkx, o_lky;
  logic      i_done_predict = 1'b0;
  logic      i_done_newlm = 1'b0;
  logic      i_done_update = 1'b0;
  rsa_data_t i_result_0 = '0;
  rsa_data_t i_result_1 = '0;
  rsa_data_t i_result_2 = '0;
  rsa_data_t i_result_3 = '0;
  rsa_data_t i_result_4 = '0;
  rsa_data_t i_result_5 = '0;
  integer    seed = 32'h9eeba18a;
  int        err_cnt;
  int        stage_cnt;
  rsa_data_t mem [0:4095];

  slam_rsa_top i_slam_rsa_top (.*);

  tb_slam_checker i_checker (
    .clk (clk), .sys_rst (sys_rst), .i_stage_val (i_stage_val), .i_l_k (i_l_k),
    .i_rk (i_rk), .i_phi (i_phi), .i_stage_rdy (o_stage_rdy),
    .i_plb_en (o_plb_en), .i_plb_we (o_plb_we), .i_plb_addr (o_plb_addr),
    .i_plb_din (o_plb_din), .i_init_predict (o_init_predict),
    .i_init_newlm (o_init_newlm), .i_init_update (o_init_update),
    .i_xk (o_xk), .i_yk (o_yk), .i_xita (o_xita), .i_lkx (o_lkx), .i_lky (o_lky),
    .i_done_predict (i_done_predict), .i_done_newlm (i_done_newlm),
    .i_done_update (i_done_update), .i_result_0 (i_result_0),
    .i_result_1 (i_result_1), .i_result_2 (i_result_2), .i_result_3 (i_result_3),
    .i_result_4 (i_result_4), .i_result_5 (i_result_5),
    .o_err_cnt (err_cnt), .o_stage_cnt (stage_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // block RAM model, one cycle read latency
  initial begin
    logic      en_q, we_q;
    plb_addr_t addr_q;
    rsa_data_t din_q;
    for (int a = 0; a < 4096; a++) begin
      mem[a] = $random(seed);
      i_checker.load_word(a, mem[a]);
    end
    forever begin
      @(posedge clk);
      en_q   = o_plb_en;
      we_q   = o_plb_we;
      addr_q = o_plb_addr;
      din_q  = o_plb_din;
      #1;
      if (en_q && we_q) mem[addr_q[13:2]] = din_q;
      if (en_q && !we_q) i_plb_dout = mem[addr_q[13:2]];
    end
  end

  // nonlinear unit model, done 1..20 cycles after init
  initial begin
    int         delay;
    logic [2:0] kind;
    delay = 0;
    kind  = '0;
    forever begin
      @(posedge clk);
      #1;
      {i_done_predict, i_done_newlm, i_done_update} = 3'b000;
      if (delay > 0) begin
        delay--;
        if (delay == 0) begin
          {i_done_predict, i_done_newlm, i_done_update} = kind;
          i_result_0 = $random(seed);
          i_result_1 = $random(seed);
          i_result_2 = $random(seed);
          i_result_3 = $random(seed);
          i_result_4 = $random(seed);
          i_result_5 = $random(seed);
        end
      end
      if (o_init_predict || o_init_newlm || o_init_update) begin
        kind  = {o_init_predict, o_init_newlm, o_init_update};
        delay = 1 + int'($unsigned($random(seed)) % 20);
      end
    end
  end

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic abort_run(input string why);
    $display("Timeout: %s", why);
    $display("Regression failed");
    $finish;
  endtask

  task automatic wait_ready();
    int t;
    t = 0;
    while (o_stage_rdy !== 1'b1 && t < WAIT_LIMIT) begin
      step();
      t++;
    end
    if (t == WAIT_LIMIT) abort_run("stage_rdy stayed low");
  endtask

  initial begin
    stage_e bad_codes [5];
    bad_codes   = '{STAGE_IDLE, stage_e'(3'd4), stage_e'(3'd5), stage_e'(3'd6), stage_e'(3'd7)};
    sys_rst     = 1'b1;
    i_stage_val = STAGE_IDLE;
    i_l_k       = '0;
    i_rk        = '0;
    i_phi       = '0;
    repeat (5) @(posedge clk);
    #1;
    sys_rst = 1'b0;
    step();
    for (int n = 0; n < N_STAGES; n++) begin
      wait_ready();
      // codes that must leave the DUT idle
      if ($unsigned($random(seed)) % 4 == 0) begin
        i_stage_val = bad_codes[$unsigned($random(seed)) % 5];
        repeat (1 + $unsigned($random(seed)) % 3) step();
      end
      // landmarks kept clear of the result region
      i_stage_val = stage_e'(3'($unsigned($random(seed)) % 3 + 1));
      i_l_k       = lm_idx_t'($unsigned($random(seed)) % 1022);
      i_rk        = $random(seed);
      i_phi       = $random(seed);
      step();
      // busy DUT must not take a second stage
      if ($unsigned($random(seed)) % 2 == 0) begin
        i_stage_val = stage_e'(3'($unsigned($random(seed)) % 8));
        i_l_k       = lm_idx_t'($unsigned($random(seed)) % 1022);
        step();
      end
      i_stage_val = STAGE_IDLE;
      step();
      wait_ready();
    end
    repeat (5) step();
    $display("Stages checked %0d of %0d, errors %0d", stage_cnt, N_STAGES, err_cnt);
    if (err_cnt == 0 && stage_cnt == N_STAGES) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* tb_slam_checker.sv */
`include "slam_macros.svh"

module tb_slam_checker
  import slam_pkg::*;
(
  input  logic      clk,
  input  logic      sys_rst,
  input  stage_e    i_stage_val,
  input  lm_idx_t   i_l_k,
  input  rsa_data_t i_rk,
  input  rsa_data_t i_phi,
  input  logic      i_stage_rdy,
  input  logic      i_plb_en,
  input  logic      i_plb_we,
  input  plb_addr_t i_plb_addr,
  input  rsa_data_t i_plb_din,
  input  logic      i_init_predict,
  input  logic      i_init_newlm,
  input  logic      i_init_update,
  input  rsa_data_t i_xk,
  input  rsa_data_t i_yk,
  input  rsa_data_t i_xita,
  input  rsa_data_t i_lkx,
  input  rsa_data_t i_lky,
  input  logic      i_done_predict,
  input  logic      i_done_newlm,
  input  logic      i_done_update,
  input  rsa_data_t i_result_0,
  input  rsa_data_t i_result_1,
  input  rsa_data_t i_result_2,
  input  rsa_data_t i_result_3,
  input  rsa_data_t i_result_4,
  input  rsa_data_t i_result_5,
  output int        o_err_cnt,
  output int        o_stage_cnt
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned RES = `PLB_RESULT_BASE;

  // shadow of the PLB memory, in words
  rsa_data_t   shadow [0:4095];
  logic        model_rdy;
  logic        reset_seen;
  stage_e      cur_stage;
  int unsigned lm_x;
  rsa_data_t   cur_rk;
  rsa_data_t   cur_phi;
  int          init_cnt;
  int          stage_errs;
  string       test_name;
  // expected read words and writes of the stage in flight
  int unsigned rd_q [$];
  int unsigned wr_addr_q [$];
  rsa_data_t   wr_data_q [$];

  // filled by the memory model before reset ends
  task automatic load_word(input int unsigned w, input rsa_data_t v);
    shadow[w] = v;
  endtask

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("Mismatch %s %s expected %h actual %h", test_name, what, exp, act);
      o_err_cnt++;
      stage_errs++;
    end
  endtask

  task automatic report_fault(input string what);
    $display("Error in %s: %s", test_name, what);
    o_err_cnt++;
    stage_errs++;
  endtask

  task automatic push_write(input int unsigned w, input rsa_data_t v);
    wr_addr_q.push_back(w);
    wr_data_q.push_back(v);
  endtask

  // writes follow from the fetched words and the done results
  task automatic build_writes();
    rsa_data_t r0, r1, r2, r3, r4, r5;
    r0 = i_result_0;
    r1 = i_result_1;
    r2 = i_result_2;
    r3 = i_result_3;
    r4 = i_result_4;
    r5 = i_result_5;
    case (cur_stage)
      STAGE_PRD: begin
        push_write(0, shadow[0] + r2);
        push_write(1, shadow[1] + r3);
        push_write(2, shadow[2] + r1);
        push_write(RES, -r3);
        push_write(RES + 1, r2);
      end
      STAGE_NEW: begin
        // x pairs with r3 and y with r2
        push_write(lm_x, shadow[lm_x] + r3);
        push_write(lm_x + 1, shadow[lm_x + 1] + r2);
        push_write(RES, r2);
        push_write(RES + 1, r3);
        push_write(RES + 2, r0);
        push_write(RES + 3, r2);
        push_write(RES + 4, r1);
        push_write(RES + 5, r3);
      end
      default: begin
        push_write(RES, -r4);
        push_write(RES + 1, -r5);
        push_write(RES + 2, r2);
        push_write(RES + 3, -r3);
        push_write(RES + 4, cur_rk - r0);
        push_write(RES + 5, cur_phi - r1);
      end
    endcase
  endtask

  // sampled mid-cycle, where every port is settled
  always @(negedge clk) begin
    if (sys_rst) begin
      model_rdy  = 1'b1;
      reset_seen = 1'b0;
      test_name  = "reset";
      rd_q.delete();
      wr_addr_q.delete();
      wr_data_q.delete();
    end else begin
      if (!reset_seen) begin
        check_value("stage_rdy", 1, 32'(i_stage_rdy));
        check_value("init", 0, 32'({i_init_predict, i_init_newlm, i_init_update}));
        check_value("plb_en", 0, 32'(i_plb_en));
        check_value("plb_we", 0, 32'(i_plb_we));
        $display("Test reset %s", (stage_errs == 0) ? "ok" : "FAILED");
        reset_seen = 1'b1;
      end
      // handshake level against the model
      check_value("stage_rdy", 32'(model_rdy), 32'(i_stage_rdy));
      if (model_rdy && (i_stage_val inside {STAGE_PRD, STAGE_NEW, STAGE_UPD})) begin
        model_rdy  = 1'b0;
        cur_stage  = i_stage_val;
        lm_x       = `PLB_LM_BASE + 2 * int'(i_l_k);
        cur_rk     = i_rk;
        cur_phi    = i_phi;
        init_cnt   = 0;
        stage_errs = 0;
        test_name  = $sformatf("stage%0d_%s", o_stage_cnt, i_stage_val.name());
        rd_q       = {0, 1, 2};
        if (cur_stage != STAGE_PRD) begin
          rd_q.push_back(lm_x);
          rd_q.push_back(lm_x + 1);
        end
      end
      if (i_plb_en && !i_plb_we) begin
        if (rd_q.size() == 0) begin
          report_fault("read outside a fetch phase");
        end else begin
          check_value("read address", rd_q.pop_front() << `PLB_BYTE_SHIFT, i_plb_addr);
        end
      end
      if (i_init_predict || i_init_newlm || i_init_update) begin
        init_cnt++;
        if (init_cnt > 1) report_fault("more than one init pulse");
        if (rd_q.size() != 0) report_fault("init pulse before the fetch ended");
        check_value("init kind",
                    32'({cur_stage == STAGE_PRD, cur_stage == STAGE_NEW, cur_stage == STAGE_UPD}),
                    32'({i_init_predict, i_init_newlm, i_init_update}));
        check_value("xk", shadow[0], i_xk);
        check_value("yk", shadow[1], i_yk);
        check_value("xita", shadow[2], i_xita);
        if (cur_stage != STAGE_PRD) begin
          check_value("lkx", shadow[lm_x], i_lkx);
          check_value("lky", shadow[lm_x + 1], i_lky);
        end
      end
      if (i_done_predict || i_done_newlm || i_done_update) begin
        build_writes();
      end
      if (i_plb_we) begin
        // a write strobe is only seen by the RAM with the port enabled
        check_value("plb_en on write", 1, 32'(i_plb_en));
        if (wr_addr_q.size() == 0) begin
          report_fault("write outside a write phase");
        end else begin
          check_value("write address", wr_addr_q.pop_front() << `PLB_BYTE_SHIFT, i_plb_addr);
          check_value("write data", wr_data_q.pop_front(), i_plb_din);
          shadow[i_plb_addr[13:2]] = i_plb_din;
          if (wr_addr_q.size() == 0) begin
            // ready is due on the next cycle
            model_rdy = 1'b1;
            o_stage_cnt++;
            $display("Test %s %s", test_name, (stage_errs == 0) ? "ok" : "FAILED");
          end
        end
      end
    end
  end

endmodule

/* slam_rsa_top.sv */
module slam_rsa_top
  import slam_pkg::*;
(
  input  logic      clk,
  input  logic      sys_rst,
  // stage handshake from the processor
  input  stage_e    i_stage_val,
  output logic      o_stage_rdy,
  input  lm_idx_t   i_l_k,
  input  rsa_data_t i_rk,
  input  rsa_data_t i_phi,
  // shared block RAM
  output logic      o_plb_en,
  output logic      o_plb_we,
  output plb_addr_t o_plb_addr,
  output rsa_data_t o_plb_din,
  input  rsa_data_t i_plb_dout,
  // nonlinear unit
  output logic      o_init_predict,
  output logic      o_init_newlm,
  output logic      o_init_update,
  output rsa_data_t o_xk,
  output rsa_data_t o_yk,
  output rsa_data_t o_xita,
  output rsa_data_t o_lkx,
  output rsa_data_t o_lky,
  input  logic      i_done_predict,
  input  logic      i_done_newlm,
  input  logic      i_done_update,
  input  rsa_data_t i_result_0,
  input  rsa_data_t i_result_1,
  input  rsa_data_t i_result_2,
  input  rsa_data_t i_result_3,
  input  rsa_data_t i_result_4,
  input  rsa_data_t i_result_5
);

  logic      rd_start, wr_start;
  logic      rd_done, wr_done;
  stage_e    stage;
  lm_idx_t   l_k;
  rsa_data_t res_0, res_1, res_2, res_3, res_4, res_5, res_6, res_7;

  slam_stage_ctrl u_stage_ctrl (
    .clk            (clk),
    .sys_rst        (sys_rst),
    .i_stage_val    (i_stage_val),
    .i_l_k          (i_l_k),
    .i_rd_done      (rd_done),
    .i_wr_done      (wr_done),
    .i_done_predict (i_done_predict),
    .i_done_newlm   (i_done_newlm),
    .i_done_update  (i_done_update),
    .o_stage_rdy    (o_stage_rdy),
    .o_stage        (stage),
    .o_l_k          (l_k),
    .o_rd_start     (rd_start),
    .o_wr_start     (wr_start),
    .o_init_predict (o_init_predict),
    .o_init_newlm   (o_init_newlm),
    .o_init_update  (o_init_update)
  );

  slam_plb_access u_plb_access (
    .clk        (clk),
    .sys_rst    (sys_rst),
    .i_rd_start (rd_start),
    .i_wr_start (wr_start),
    .i_stage    (stage),
    .i_l_k      (l_k),
    .i_plb_dout (i_plb_dout),
    .i_res_0    (res_0),
    .i_res_1    (res_1),
    .i_res_2    (res_2),
    .i_res_3    (res_3),
    .i_res_4    (res_4),
    .i_res_5    (res_5),
    .i_res_6    (res_6),
    .i_res_7    (res_7),
    .o_plb_en   (o_plb_en),
    .o_plb_we   (o_plb_we),
    .o_plb_addr (o_plb_addr),
    .o_plb_din  (o_plb_din),
    .o_rd_done  (rd_done),
    .o_wr_done  (wr_done),
    .o_xk       (o_xk),
    .o_yk       (o_yk),
    .o_xita     (o_xita),
    .o_lkx      (o_lkx),
    .o_lky      (o_lky)
  );

  slam_nl_capture u_nl_capture (
    .clk            (clk),
    .sys_rst        (sys_rst),
    .i_done_predict (i_done_predict),
    .i_done_newlm   (i_done_newlm),
    .i_done_update  (i_done_update),
    .i_result_0     (i_result_0),
    .i_result_1     (i_result_1),
    .i_result_2     (i_result_2),
    .i_result_3     (i_result_3),
    .i_result_4     (i_result_4),
    .i_result_5     (i_result_5),
    .i_xk           (o_xk),
    .i_yk           (o_yk),
    .i_xita         (o_xita),
    .i_lkx          (o_lkx),
    .i_lky          (o_lky),
    .i_rk           (i_rk),
    .i_phi          (i_phi),
    .o_res_0        (res_0),
    .o_res_1        (res_1),
    .o_res_2        (res_2),
    .o_res_3        (res_3),
    .o_res_4        (res_4),
    .o_res_5        (res_5),
    .o_res_6        (res_6),
    .o_res_7        (res_7)
  );

endmodule

/* slam_nl_capture.sv */
module slam_nl_capture
  import slam_pkg::*;
(
  input  logic      clk,
  input  logic      sys_rst,
  input  logic      i_done_predict,
  input  logic      i_done_newlm,
  input  logic      i_done_update,
  input  rsa_data_t i_result_0,
  input  rsa_data_t i_result_1,
  input  rsa_data_t i_result_2,
  input  rsa_data_t i_result_3,
  input  rsa_data_t i_result_4,
  input  rsa_data_t i_result_5,
  input  rsa_data_t i_xk,
  input  rsa_data_t i_yk,
  input  rsa_data_t i_xita,
  input  rsa_data_t i_lkx,
  input  rsa_data_t i_lky,
  input  rsa_data_t i_rk,
  input  rsa_data_t i_phi,
  output rsa_data_t o_res_0,
  output rsa_data_t o_res_1,
  output rsa_data_t o_res_2,
  output rsa_data_t o_res_3,
  output rsa_data_t o_res_4,
  output rsa_data_t o_res_5,
  output rsa_data_t o_res_6,
  output rsa_data_t o_res_7
);

  // predict group
  rsa_data_t x_hat, y_hat, xita_hat;
  rsa_data_t fxi_13, fxi_23;
  // new landmark group
  rsa_data_t lkx_hat, lky_hat;
  rsa_data_t gxi_13, gxi_23, gz_11, gz_12, gz_21, gz_22;
  // update group, Hz is just -Hxi so it is not kept
  rsa_data_t hxi_11, hxi_12, hxi_21, hxi_22;
  rsa_data_t vt_1, vt_2;
  // which group feeds the write words
  stage_e    last_stage;

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      x_hat    <= '0;
      y_hat    <= '0;
      xita_hat <= '0;
      fxi_13   <= '0;
      fxi_23   <= '0;
    end else if (i_done_predict) begin
      x_hat    <= i_xk + i_result_2;
      y_hat    <= i_yk + i_result_3;
      xita_hat <= i_xita + i_result_1;
      fxi_13   <= -i_result_3;
      fxi_23   <= i_result_2;
    end
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      lkx_hat <= '0;
      lky_hat <= '0;
      gxi_13  <= '0;
      gxi_23  <= '0;
      gz_11   <= '0;
      gz_12   <= '0;
      gz_21   <= '0;
      gz_22   <= '0;
    end else if (i_done_newlm) begin
      // note x pairs with r3 and y with r2
      lkx_hat <= i_lkx + i_result_3;
      lky_hat <= i_lky + i_result_2;
      gxi_13  <= i_result_2;
      gxi_23  <= i_result_3;
      gz_11   <= i_result_0;
      gz_12   <= i_result_2;
      gz_21   <= i_result_1;
      gz_22   <= i_result_3;
    end
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      hxi_11 <= '0;
      hxi_12 <= '0;
      hxi_21 <= '0;
      hxi_22 <= '0;
      vt_1   <= '0;
      vt_2   <= '0;
    end else if (i_done_update) begin
      hxi_11 <= -i_result_4;
      hxi_12 <= -i_result_5;
      hxi_21 <= i_result_2;
      hxi_22 <= -i_result_3;
      // rk and phi taken live, the host keeps them for the whole stage
      vt_1   <= i_rk - i_result_0;
      vt_2   <= i_phi - i_result_1;
    end
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      last_stage <= STAGE_IDLE;
    end else if (i_done_predict) begin
      last_stage <= STAGE_PRD;
    end else if (i_done_newlm) begin
      last_stage <= STAGE_NEW;
    end else if (i_done_update) begin
      last_stage <= STAGE_UPD;
    end
  end

  // write words in PLB write order
  always_comb begin
    o_res_0 = '0;
    o_res_1 = '0;
    o_res_2 = '0;
    o_res_3 = '0;
    o_res_4 = '0;
    o_res_5 = '0;
    o_res_6 = '0;
    o_res_7 = '0;
    case (last_stage)
      STAGE_PRD: begin
        o_res_0 = x_hat;
        o_res_1 = y_hat;
        o_res_2 = xita_hat;
        o_res_3 = fxi_13;
        o_res_4 = fxi_23;
      end
      STAGE_NEW: begin
        o_res_0 = lkx_hat;
        o_res_1 = lky_hat;
        o_res_2 = gxi_13;
        o_res_3 = gxi_23;
        o_res_4 = gz_11;
        o_res_5 = gz_12;
        o_res_6 = gz_21;
        o_res_7 = gz_22;
      end
      STAGE_UPD: begin
        o_res_0 = hxi_11;
        o_res_1 = hxi_12;
        o_res_2 = hxi_21;
        o_res_3 = hxi_22;
        o_res_4 = vt_1;
        o_res_5 = vt_2;
      end
      default: ;
    endcase
  end

  // nonlinear unit runs one job at a time
  a_done_onehot: assert property (@(posedge clk) disable iff (sys_rst)
    $onehot0({i_done_predict, i_done_newlm, i_done_update}));

endmodule

/* slam_plb_access.sv */
`include "slam_macros.svh"

module slam_plb_access
  import slam_pkg::*;
(
  input  logic      clk,
  input  logic      sys_rst,
  input  logic      i_rd_start,
  input  logic      i_wr_start,
  input  stage_e    i_stage,
  input  lm_idx_t   i_l_k,
  input  rsa_data_t i_plb_dout,
  input  rsa_data_t i_res_0,
  input  rsa_data_t i_res_1,
  input  rsa_data_t i_res_2,
  input  rsa_data_t i_res_3,
  input  rsa_data_t i_res_4,
  input  rsa_data_t i_res_5,
  input  rsa_data_t i_res_6,
  input  rsa_data_t i_res_7,
  output logic      o_plb_en,
  output logic      o_plb_we,
  output plb_addr_t o_plb_addr,
  output rsa_data_t o_plb_din,
  output logic      o_rd_done,
  output logic      o_wr_done,
  output rsa_data_t o_xk,
  output rsa_data_t o_yk,
  output rsa_data_t o_xita,
  output rsa_data_t o_lkx,
  output rsa_data_t o_lky
);

  // pose words, then one landmark pair
  localparam word_cnt_t ROBOT_WORDS = word_cnt_t'(`RD_WORDS_PRD);
  localparam word_cnt_t LM_WORDS    = word_cnt_t'(`RD_WORDS_LM - `RD_WORDS_PRD);

  logic      busy;
  logic      wr_mode;
  word_cnt_t cnt;
  logic      run;
  logic      wr_phase;
  logic      last;
  word_cnt_t n_words;
  logic      rd_vld_d;
  word_cnt_t rd_cnt_d;
  plb_addr_t lm_word;
  plb_addr_t cnt_ext;
  plb_addr_t word_idx;
  rsa_data_t wr_words [0:7];

  // a start pulse drives word 0 in its own cycle
  assign run      = i_rd_start || i_wr_start || busy;
  assign wr_phase = i_wr_start || (busy && wr_mode);

  always_comb begin
    if (wr_phase) begin
      case (i_stage)
        STAGE_PRD: n_words = word_cnt_t'(`WR_WORDS_PRD);
        STAGE_NEW: n_words = word_cnt_t'(`WR_WORDS_NEW);
        default:   n_words = word_cnt_t'(`WR_WORDS_UPD);
      endcase
    end else begin
      // predict skips the landmark pair
      n_words = (i_stage == STAGE_PRD) ? ROBOT_WORDS : word_cnt_t'(`RD_WORDS_LM);
    end
  end

  assign last = (cnt == n_words - word_cnt_t'(1));

  // word index per phase and stage
  always_comb begin
    lm_word = plb_addr_t'(`PLB_LM_BASE) + (plb_addr_t'(i_l_k) << 1);
    cnt_ext = plb_addr_t'(cnt);
    if (!wr_phase) begin
      if (cnt < ROBOT_WORDS) begin
        word_idx = plb_addr_t'(`PLB_ROBOT_BASE) + cnt_ext;
      end else begin
        word_idx = lm_word + cnt_ext - plb_addr_t'(ROBOT_WORDS);
      end
    end else begin
      case (i_stage)
        STAGE_PRD: begin
          // updated pose, then Fxi terms
          if (cnt < ROBOT_WORDS) begin
            word_idx = plb_addr_t'(`PLB_ROBOT_BASE) + cnt_ext;
          end else begin
            word_idx = plb_addr_t'(`PLB_RESULT_BASE) + cnt_ext - plb_addr_t'(ROBOT_WORDS);
          end
        end
        STAGE_NEW: begin
          // new landmark slot, then G terms
          if (cnt < LM_WORDS) begin
            word_idx = lm_word + cnt_ext;
          end else begin
            word_idx = plb_addr_t'(`PLB_RESULT_BASE) + cnt_ext - plb_addr_t'(LM_WORDS);
          end
        end
        default: word_idx = plb_addr_t'(`PLB_RESULT_BASE) + cnt_ext;
      endcase
    end
  end

  always_comb begin
    wr_words[0] = i_res_0;
    wr_words[1] = i_res_1;
    wr_words[2] = i_res_2;
    wr_words[3] = i_res_3;
    wr_words[4] = i_res_4;
    wr_words[5] = i_res_5;
    wr_words[6] = i_res_6;
    wr_words[7] = i_res_7;
  end

  assign o_plb_en   = run;
  assign o_plb_we   = wr_phase;
  assign o_plb_addr = word_idx << `PLB_BYTE_SHIFT;
  assign o_plb_din  = wr_words[cnt[2:0]];
  assign o_wr_done  = wr_phase && last;

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      busy      <= 1'b0;
      wr_mode   <= 1'b0;
      cnt       <= '0;
      rd_vld_d  <= 1'b0;
      o_rd_done <= 1'b0;
    end else begin
      rd_vld_d  <= run && !wr_phase;
      // high while the last read word is being registered
      o_rd_done <= run && !wr_phase && last;
      if (run) begin
        if (last) begin
          busy <= 1'b0;
          cnt  <= '0;
        end else begin
          busy    <= 1'b1;
          wr_mode <= wr_phase;
          cnt     <= cnt + word_cnt_t'(1);
        end
      end
    end
  end

  // read data trails its address by one cycle
  always_ff @(posedge clk) begin
    rd_cnt_d <= cnt;
    if (rd_vld_d) begin
      case (rd_cnt_d)
        4'd0:    o_xk   <= i_plb_dout;
        4'd1:    o_yk   <= i_plb_dout;
        4'd2:    o_xita <= i_plb_dout;
        4'd3:    o_lkx  <= i_plb_dout;
        4'd4:    o_lky  <= i_plb_dout;
        default: ;
      endcase
    end
  end

  // a read cycle is never directly followed by a write
  a_no_we_after_read: assert property (@(posedge clk) disable iff (sys_rst)
    (o_plb_en && !o_plb_we) |=> !$rose(o_plb_we));

  a_addr_range: assert property (@(posedge clk) disable iff (sys_rst)
    o_plb_en |->
    (o_plb_addr >> `PLB_BYTE_SHIFT) < (`PLB_RESULT_BASE + `PLB_RESULT_WORDS));

endmodule

/* slam_stage_ctrl.sv */
module slam_stage_ctrl
  import slam_pkg::*;
(
  input  logic    clk,
  input  logic    sys_rst,
  input  stage_e  i_stage_val,
  input  lm_idx_t i_l_k,
  input  logic    i_rd_done,
  input  logic    i_wr_done,
  input  logic    i_done_predict,
  input  logic    i_done_newlm,
  input  logic    i_done_update,
  output logic    o_stage_rdy,
  output stage_e  o_stage,
  output lm_idx_t o_l_k,
  output logic    o_rd_start,
  output logic    o_wr_start,
  output logic    o_init_predict,
  output logic    o_init_newlm,
  output logic    o_init_update
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FETCH,
    ST_WAIT_NL,
    ST_WRITE
  } ctrl_state_e;

  ctrl_state_e state;
  logic        accept;
  logic        nl_done;

  // only the three served codes start a stage
  assign accept = (state == ST_IDLE) &&
                  (i_stage_val inside {STAGE_PRD, STAGE_NEW, STAGE_UPD});

  assign o_stage_rdy = (state == ST_IDLE);

  // done pulse of the latched stage, others are dropped
  always_comb begin
    case (o_stage)
      STAGE_PRD: nl_done = i_done_predict;
      STAGE_NEW: nl_done = i_done_newlm;
      STAGE_UPD: nl_done = i_done_update;
      default:   nl_done = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      state          <= ST_IDLE;
      o_stage        <= STAGE_IDLE;
      o_l_k          <= '0;
      o_rd_start     <= 1'b0;
      o_wr_start     <= 1'b0;
      o_init_predict <= 1'b0;
      o_init_newlm   <= 1'b0;
      o_init_update  <= 1'b0;
    end else begin
      // all starts and inits are single cycle
      o_rd_start     <= 1'b0;
      o_wr_start     <= 1'b0;
      o_init_predict <= 1'b0;
      o_init_newlm   <= 1'b0;
      o_init_update  <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (accept) begin
            state      <= ST_FETCH;
            o_stage    <= i_stage_val;
            o_l_k      <= i_l_k;
            o_rd_start <= 1'b1;
          end
        end
        ST_FETCH: begin
          // last word lands this edge, so init sees a full pose
          if (i_rd_done) begin
            state          <= ST_WAIT_NL;
            o_init_predict <= (o_stage == STAGE_PRD);
            o_init_newlm   <= (o_stage == STAGE_NEW);
            o_init_update  <= (o_stage == STAGE_UPD);
          end
        end
        ST_WAIT_NL: begin
          if (nl_done) begin
            state      <= ST_WRITE;
            o_wr_start <= 1'b1;
          end
        end
        ST_WRITE: begin
          // wr_done marks the final write cycle
          if (i_wr_done) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  a_init_onehot: assert property (@(posedge clk) disable iff (sys_rst)
    $onehot0({o_init_predict, o_init_newlm, o_init_update}));

  a_init_single: assert property (@(posedge clk) disable iff (sys_rst)
    (o_init_predict || o_init_newlm || o_init_update) |=>
    !(o_init_predict || o_init_newlm || o_init_update));

  // read phase ends only while fetching
  a_rd_done_fetch: assert property (@(posedge clk) disable iff (sys_rst)
    i_rd_done |-> (state == ST_FETCH));

  // write phase ends only while writing
  a_wr_done_write: assert property (@(posedge clk) disable iff (sys_rst)
    i_wr_done |-> (state == ST_WRITE));

endmodule

/* slam_pkg.sv */
`include "slam_macros.svh"

package slam_pkg;

  // one signed datapath word, pose, landmark or result
  typedef logic signed [`RSA_DW-1:0] rsa_data_t;

  // PLB byte address
  typedef logic [`PLB_AW-1:0] plb_addr_t;

  // landmark number within the map
  typedef logic [`ROW_LEN-1:0] lm_idx_t;

  // words moved within one read or write phase
  typedef logic [3:0] word_cnt_t;

  // stage codes from the processor
  // association (4) is not served here, codes 4..7 are ignored
  typedef enum logic [2:0] {
    STAGE_IDLE = 3'd0,
    STAGE_PRD  = 3'd1,
    STAGE_NEW  = 3'd2,
    STAGE_UPD  = 3'd3
  } stage_e;

endpackage

/* slam_macros.svh */
`ifndef SLAM_MACROS_SVH
`define SLAM_MACROS_SVH

// datapath word and landmark index widths
`define RSA_DW           32
`define ROW_LEN          10
`define PLB_AW           32

// PLB memory map, in words
// robot pose xk, yk, xita
`define PLB_ROBOT_BASE   0
// landmark n at 3+2n (x) and 4+2n (y)
`define PLB_LM_BASE      3
// Jacobians and innovation for the processor
`define PLB_RESULT_BASE  2048
`define PLB_RESULT_WORDS 8
// word index to byte address
`define PLB_BYTE_SHIFT   2

// words per phase
`define RD_WORDS_PRD     3
`define RD_WORDS_LM      5
`define WR_WORDS_PRD     5
`define WR_WORDS_NEW     8
`define WR_WORDS_UPD     6

`endif
